// File: hdl/softermax_pkg.sv
/*
  Widths of the Softermax exponent stage
  Chord slope and intercept tables of 2^f on the four quarters of [0, 1)
*/

package softermax_pkg;

  // Scores, signed Q4.4
  localparam int IN_WIDTH = 8;
  localparam int IN_FRAC_WIDTH = 4;
  localparam int INT_WIDTH = IN_WIDTH - IN_FRAC_WIDTH;

  // Numerators, unsigned Q1.7
  localparam int OUT_WIDTH = 8;
  localparam int OUT_FRAC_WIDTH = 7;

  // Chord slope m, Q2.8, and the product f * m, Q2.12
  localparam int SLOPE_FRAC_WIDTH = 8;
  localparam int SLOPE_WIDTH = 10;
  localparam int MULT_WIDTH = IN_FRAC_WIDTH + SLOPE_WIDTH;

  // Chord intercept c, same fraction as the product
  localparam int ICPT_FRAC_WIDTH = IN_FRAC_WIDTH + SLOPE_FRAC_WIDTH;
  localparam int LPW_WIDTH = MULT_WIDTH + 1;

  // Row sum, unsigned Q9.7
  localparam int SUM_WIDTH = 16;

  // Entry k is the chord between f = k/4 and f = (k+1)/4
  localparam logic [SLOPE_WIDTH-1:0] SLOPE_TABLE [4] = '{10'd194, 10'd230, 10'd274, 10'd326};
  localparam logic [ICPT_FRAC_WIDTH:0] INTERCEPT_TABLE [4] =
    '{13'd4096, 13'd3949, 13'd3601, 13'd2978};

endpackage

// File: hdl/skid_buffer.sv
/*
  Two-entry valid/ready register slice
  Main register drives the output, skid register catches one beat on a stall
*/

`timescale 1ns/1ps

module skid_buffer #(
  parameter int DATA_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [DATA_WIDTH-1:0] in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [DATA_WIDTH-1:0] skid_data;
  logic                  skid_valid;
  logic                  in_fire;
  logic                  stall;

  assign in_fire = in_valid & in_ready;
  assign stall   = out_valid & ~out_ready;

  // in_ready is kept equal to the inverse of skid_valid, as a flop of its own
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else if (stall) begin
      // Output held, a new beat parks in the skid register
      if (in_fire) begin
        skid_valid <= 1'b1;
        in_ready   <= 1'b0;
      end
    end else if (skid_valid) begin
      out_valid  <= 1'b1;
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else begin
      out_valid <= in_fire;
    end
  end

  always_ff @(posedge clk) begin
    if (stall) begin
      if (in_fire) begin
        skid_data <= in_data;
      end
    end else if (skid_valid) begin
      out_data <= skid_data;
    end else if (in_fire) begin
      out_data <= in_data;
    end
  end

endmodule

// File: hdl/softermax_running_max.sv
/*
  Per-row running integer maximum of Q4.4 scores
  Outputs score minus maximum, the maximum and its increase, one register deep
*/

`timescale 1ns/1ps

module softermax_running_max (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [softermax_pkg::IN_WIDTH-1:0]   score_data,
  input  logic                                 score_last,
  input  logic                                 score_valid,
  output logic                                 score_ready,
  output logic [softermax_pkg::IN_WIDTH-1:0]   diff_data,
  output logic [softermax_pkg::INT_WIDTH-1:0]  max_data,
  output logic [softermax_pkg::INT_WIDTH-1:0]  max_delta,
  output logic                                 last,
  output logic                                 out_valid,
  input  logic                                 out_ready
);

  logic [softermax_pkg::INT_WIDTH-1:0]     score_int;
  logic                                    frac_nz;
  logic [softermax_pkg::INT_WIDTH:0]       ceil_wide;
  logic [softermax_pkg::INT_WIDTH-1:0]     ceil_int;
  logic [softermax_pkg::INT_WIDTH-1:0]     row_max;
  logic                                    row_open;
  logic [softermax_pkg::INT_WIDTH-1:0]     new_max;
  logic [softermax_pkg::INT_WIDTH-1:0]     new_delta;
  logic signed [softermax_pkg::IN_WIDTH:0] diff_wide;
  logic [softermax_pkg::IN_WIDTH-1:0]      diff_sat;
  logic                                    score_fire;

  assign score_int = score_data[softermax_pkg::IN_WIDTH-1:softermax_pkg::IN_FRAC_WIDTH];
  assign frac_nz   = |score_data[softermax_pkg::IN_FRAC_WIDTH-1:0];
  assign score_fire = score_valid & score_ready;

  // Ceiling of the score; scores above 7 saturate to 7, the largest maximum
  assign ceil_wide = {score_int[softermax_pkg::INT_WIDTH-1], score_int} +
                     {{softermax_pkg::INT_WIDTH{1'b0}}, frac_nz};
  assign ceil_int = (ceil_wide[softermax_pkg::INT_WIDTH] != ceil_wide[softermax_pkg::INT_WIDTH-1])
                  ? {1'b0, {(softermax_pkg::INT_WIDTH-1){1'b1}}}
                  : ceil_wide[softermax_pkg::INT_WIDTH-1:0];

  always_comb begin
    if (!row_open || ($signed(ceil_int) > $signed(row_max))) begin
      new_max = ceil_int;
    end else begin
      new_max = row_max;
    end
    new_delta = row_open ? (new_max - row_max) : '0;
  end

  // x - max, clamped to [-8, 0]; both ends give the same numerator as the exact value
  assign diff_wide = $signed({score_data[softermax_pkg::IN_WIDTH-1], score_data}) -
                     $signed({new_max[softermax_pkg::INT_WIDTH-1], new_max,
                              {softermax_pkg::IN_FRAC_WIDTH{1'b0}}});

  always_comb begin
    if (diff_wide[softermax_pkg::IN_WIDTH] && !diff_wide[softermax_pkg::IN_WIDTH-1]) begin
      diff_sat = {1'b1, {(softermax_pkg::IN_WIDTH-1){1'b0}}};
    end else if (!diff_wide[softermax_pkg::IN_WIDTH] && (diff_wide != '0)) begin
      diff_sat = '0;
    end else begin
      diff_sat = diff_wide[softermax_pkg::IN_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      row_max  <= '0;
      row_open <= 1'b0;
    end else if (score_fire) begin
      row_max  <= score_last ? '0 : new_max;
      row_open <= ~score_last;
    end
  end

  skid_buffer #(
    .DATA_WIDTH(softermax_pkg::IN_WIDTH + 2 * softermax_pkg::INT_WIDTH + 1)
  ) i_out_reg (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  ({diff_sat, new_max, new_delta, score_last}),
    .in_valid (score_valid),
    .in_ready (score_ready),
    .out_data ({diff_data, max_data, max_delta, last}),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

// File: hdl/softermax_lpw_pow2.sv
/*
  Linear-piecewise 2^x for non-positive Q4.4 inputs
  Multiply, intercept and shift stages, then floor to Q1.7 and an output register
  Row maximum, max increase and last travel alongside as sideband
*/

`timescale 1ns/1ps

module softermax_lpw_pow2 (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [softermax_pkg::IN_WIDTH-1:0]   in_data,
  input  logic [softermax_pkg::INT_WIDTH-1:0]  in_max,
  input  logic [softermax_pkg::INT_WIDTH-1:0]  in_delta,
  input  logic                                 in_last,
  input  logic                                 in_valid,
  output logic                                 in_ready,
  output logic [softermax_pkg::OUT_WIDTH-1:0]  out_data,
  output logic [softermax_pkg::INT_WIDTH-1:0]  out_max,
  output logic [softermax_pkg::INT_WIDTH-1:0]  out_delta,
  output logic                                 out_last,
  output logic                                 out_valid,
  input  logic                                 out_ready
);

  localparam int FLOOR_WIDTH = softermax_pkg::LPW_WIDTH - softermax_pkg::ICPT_FRAC_WIDTH +
                               softermax_pkg::OUT_FRAC_WIDTH;

  logic [softermax_pkg::INT_WIDTH-1:0]     in_int;
  logic [softermax_pkg::IN_FRAC_WIDTH-1:0] in_frac;
  logic [1:0]                              in_sel;
  logic [softermax_pkg::MULT_WIDTH-1:0]    mult_in;

  logic [softermax_pkg::MULT_WIDTH-1:0]    mult_q;
  logic [1:0]                              mult_sel;
  logic [softermax_pkg::INT_WIDTH-1:0]     mult_int;
  logic [softermax_pkg::INT_WIDTH-1:0]     mult_max;
  logic [softermax_pkg::INT_WIDTH-1:0]     mult_delta;
  logic                                    mult_last;
  logic                                    mult_valid;
  logic                                    mult_ready;

  logic [softermax_pkg::LPW_WIDTH-1:0]     icpt_in;
  logic [softermax_pkg::LPW_WIDTH-1:0]     icpt_q;
  logic [softermax_pkg::INT_WIDTH-1:0]     icpt_int;
  logic [softermax_pkg::INT_WIDTH-1:0]     icpt_max;
  logic [softermax_pkg::INT_WIDTH-1:0]     icpt_delta;
  logic                                    icpt_last;
  logic                                    icpt_valid;
  logic                                    icpt_ready;

  logic [softermax_pkg::INT_WIDTH:0]       shift_amt;
  logic [softermax_pkg::LPW_WIDTH-1:0]     shift_in;
  logic [softermax_pkg::LPW_WIDTH-1:0]     shift_q;
  logic [softermax_pkg::INT_WIDTH-1:0]     shift_max;
  logic [softermax_pkg::INT_WIDTH-1:0]     shift_delta;
  logic                                    shift_last;
  logic                                    shift_valid;
  logic                                    shift_ready;

  logic [FLOOR_WIDTH-1:0]                  pow_floor;
  logic [softermax_pkg::OUT_WIDTH-1:0]     pow_sat;

  // Integer part n <= 0 and fraction f; top two fraction bits pick the chord
  assign {in_int, in_frac} = in_data;
  assign in_sel  = in_frac[softermax_pkg::IN_FRAC_WIDTH-1 -: 2];
  assign mult_in = in_frac * softermax_pkg::SLOPE_TABLE[in_sel];

  skid_buffer #(
    .DATA_WIDTH(softermax_pkg::MULT_WIDTH + 2 + 3 * softermax_pkg::INT_WIDTH + 1)
  ) i_mult_reg (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  ({mult_in, in_sel, in_int, in_max, in_delta, in_last}),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .out_data ({mult_q, mult_sel, mult_int, mult_max, mult_delta, mult_last}),
    .out_valid(mult_valid),
    .out_ready(mult_ready)
  );

  // f * m + c in Q3.12
  assign icpt_in = mult_q + softermax_pkg::INTERCEPT_TABLE[mult_sel];

  skid_buffer #(
    .DATA_WIDTH(softermax_pkg::LPW_WIDTH + 3 * softermax_pkg::INT_WIDTH + 1)
  ) i_icpt_reg (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  ({icpt_in, mult_int, mult_max, mult_delta, mult_last}),
    .in_valid (mult_valid),
    .in_ready (mult_ready),
    .out_data ({icpt_q, icpt_int, icpt_max, icpt_delta, icpt_last}),
    .out_valid(icpt_valid),
    .out_ready(icpt_ready)
  );

  // Shift right by -n, at most 8 places
  assign shift_amt = '0 - {icpt_int[softermax_pkg::INT_WIDTH-1], icpt_int};
  assign shift_in  = icpt_q >> shift_amt;

  skid_buffer #(
    .DATA_WIDTH(softermax_pkg::LPW_WIDTH + 2 * softermax_pkg::INT_WIDTH + 1)
  ) i_shift_reg (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  ({shift_in, icpt_max, icpt_delta, icpt_last}),
    .in_valid (icpt_valid),
    .in_ready (icpt_ready),
    .out_data ({shift_q, shift_max, shift_delta, shift_last}),
    .out_valid(shift_valid),
    .out_ready(shift_ready)
  );

  // Floor to Q1.7 by dropping fraction bits, then cap at 1.0
  assign pow_floor = shift_q[softermax_pkg::LPW_WIDTH-1:
                             softermax_pkg::ICPT_FRAC_WIDTH - softermax_pkg::OUT_FRAC_WIDTH];
  assign pow_sat = (pow_floor > {1'b1, {softermax_pkg::OUT_FRAC_WIDTH{1'b0}}})
                 ? {1'b1, {softermax_pkg::OUT_FRAC_WIDTH{1'b0}}}
                 : pow_floor[softermax_pkg::OUT_WIDTH-1:0];

  skid_buffer #(
    .DATA_WIDTH(softermax_pkg::OUT_WIDTH + 2 * softermax_pkg::INT_WIDTH + 1)
  ) i_out_reg (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  ({pow_sat, shift_max, shift_delta, shift_last}),
    .in_valid (shift_valid),
    .in_ready (shift_ready),
    .out_data ({out_data, out_max, out_delta, out_last}),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

// File: hdl/softermax_denom_accum.sv
/*
  Base-2 row sum of the numerators
  Old sum is shifted right by the max increase before each add
  The sum leaves with each numerator and is the row total on the last beat
*/

`timescale 1ns/1ps

module softermax_denom_accum (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [softermax_pkg::OUT_WIDTH-1:0]  pow_data,
  input  logic [softermax_pkg::INT_WIDTH-1:0]  pow_max,
  input  logic [softermax_pkg::INT_WIDTH-1:0]  pow_delta,
  input  logic                                 pow_last,
  input  logic                                 pow_valid,
  output logic                                 pow_ready,
  output logic [softermax_pkg::OUT_WIDTH-1:0]  num_data,
  output logic [softermax_pkg::INT_WIDTH-1:0]  num_max,
  output logic                                 num_last,
  output logic [softermax_pkg::SUM_WIDTH-1:0]  row_sum,
  output logic                                 out_valid,
  input  logic                                 out_ready
);

  logic [softermax_pkg::SUM_WIDTH-1:0] run_sum;
  logic [softermax_pkg::SUM_WIDTH-1:0] sum_next;
  logic                                pow_fire;

  assign pow_fire = pow_valid & pow_ready;

  // Rescale to the new maximum, then add the numerator; both in Q.7
  // The first beat of a row sees a cleared sum and a zero increase
  assign sum_next = (run_sum >> pow_delta) +
                    {{(softermax_pkg::SUM_WIDTH - softermax_pkg::OUT_WIDTH){1'b0}}, pow_data};

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      run_sum <= '0;
    end else if (pow_fire) begin
      // Next row starts from zero
      if (pow_last) begin
        run_sum <= '0;
      end else begin
        run_sum <= sum_next;
      end
    end
  end

  skid_buffer #(
    .DATA_WIDTH(softermax_pkg::OUT_WIDTH + softermax_pkg::INT_WIDTH + 1 +
                softermax_pkg::SUM_WIDTH)
  ) i_out_reg (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  ({pow_data, pow_max, pow_last, sum_next}),
    .in_valid (pow_valid),
    .in_ready (pow_ready),
    .out_data ({num_data, num_max, num_last, row_sum}),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

// File: hdl/softermax_top.sv
/*
  Softermax exponent stage
  Running max, then pow2, then the denominator accumulator
*/

`timescale 1ns/1ps

module softermax_top (
  input  logic                                 clk,
  input  logic                                 arst_n,
  input  logic [softermax_pkg::IN_WIDTH-1:0]   score_data,
  input  logic                                 score_last,
  input  logic                                 score_valid,
  output logic                                 score_ready,
  output logic [softermax_pkg::OUT_WIDTH-1:0]  num_data,
  output logic [softermax_pkg::INT_WIDTH-1:0]  num_max,
  output logic                                 num_last,
  output logic [softermax_pkg::SUM_WIDTH-1:0]  row_sum,
  output logic                                 out_valid,
  input  logic                                 out_ready
);

  // Running max to pow2
  logic [softermax_pkg::IN_WIDTH-1:0]  diff_data;
  logic [softermax_pkg::INT_WIDTH-1:0] max_data;
  logic [softermax_pkg::INT_WIDTH-1:0] max_delta;
  logic                                max_last;
  logic                                max_valid;
  logic                                max_ready;

  // Pow2 to accumulator
  logic [softermax_pkg::OUT_WIDTH-1:0] pow_data;
  logic [softermax_pkg::INT_WIDTH-1:0] pow_max;
  logic [softermax_pkg::INT_WIDTH-1:0] pow_delta;
  logic                                pow_last;
  logic                                pow_valid;
  logic                                pow_ready;

  softermax_running_max i_running_max (
    .clk        (clk),
    .arst_n     (arst_n),
    .score_data (score_data),
    .score_last (score_last),
    .score_valid(score_valid),
    .score_ready(score_ready),
    .diff_data  (diff_data),
    .max_data   (max_data),
    .max_delta  (max_delta),
    .last       (max_last),
    .out_valid  (max_valid),
    .out_ready  (max_ready)
  );

  softermax_lpw_pow2 i_lpw_pow2 (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_data  (diff_data),
    .in_max   (max_data),
    .in_delta (max_delta),
    .in_last  (max_last),
    .in_valid (max_valid),
    .in_ready (max_ready),
    .out_data (pow_data),
    .out_max  (pow_max),
    .out_delta(pow_delta),
    .out_last (pow_last),
    .out_valid(pow_valid),
    .out_ready(pow_ready)
  );

  softermax_denom_accum i_denom_accum (
    .clk      (clk),
    .arst_n   (arst_n),
    .pow_data (pow_data),
    .pow_max  (pow_max),
    .pow_delta(pow_delta),
    .pow_last (pow_last),
    .pow_valid(pow_valid),
    .pow_ready(pow_ready),
    .num_data (num_data),
    .num_max  (num_max),
    .num_last (num_last),
    .row_sum  (row_sum),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

// File: sim/tb_clock_gen.sv
/*
  Testbench clock, period 100 ns, and a reset held low for 4 cycles
*/

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    repeat (4) @(posedge clk);
    #10 arst_n = 1'b1;
  end

endmodule

// File: sim/softermax_tb.sv
/*
  Testbench of the Softermax exponent stage
  Reference model from real-valued chords, stimulus, concurrent checks,
  watchdog and the closing report
*/

`timescale 1ns/1ps

module softermax_tb;

  localparam int RAND_ROWS = 6;
  localparam int BP_ROWS = 8;
  localparam int QP_LEN = 13;
  // Quarter points in Q4.4, repeats of the maximum and one rise of it
  localparam int QP_SCORES [QP_LEN] = '{32, 28, 24, 20, 16, 12, 8, 4, 0, -4, 32, 48, -60};
  localparam int DRIVE_DELAY = 10;
  localparam int LATENCY = 6;
  localparam int FRAC = softermax_pkg::IN_FRAC_WIDTH;
  localparam int EXP_WIDTH = softermax_pkg::OUT_WIDTH + softermax_pkg::INT_WIDTH + 1 +
                             softermax_pkg::SUM_WIDTH;

  logic                                clk;
  logic                                arst_n;
  logic [softermax_pkg::IN_WIDTH-1:0]  score_data;
  logic                                score_last;
  logic                                score_valid;
  logic                                score_ready;
  logic [softermax_pkg::OUT_WIDTH-1:0] num_data;
  logic [softermax_pkg::INT_WIDTH-1:0] num_max;
  logic                                num_last;
  logic [softermax_pkg::SUM_WIDTH-1:0] row_sum;
  logic                                out_valid;
  logic                                out_ready;

  // Expected beats as {numerator, maximum, last, row sum}
  logic [EXP_WIDTH-1:0]                exp_q [$];
  logic                                head_valid;
  logic [softermax_pkg::OUT_WIDTH-1:0] head_data;
  logic [softermax_pkg::INT_WIDTH-1:0] head_max;
  logic                                head_last;
  logic [softermax_pkg::SUM_WIDTH-1:0] head_sum;

  int    chord_slope [4];
  int    chord_icpt [4];
  bit    row_open;
  int    row_max;
  int    run_sum;
  int    cycle_cnt = 0;
  int    in_cycle;
  int    out_cycle;
  int    beats_in = 0;
  int    beats_out = 0;
  int    err_count = 0;
  int    test_errs;
  int    tests_run = 0;
  int    tests_failed = 0;
  bit    bp_on;
  string test_name = "none";

  tb_clock_gen i_clock_gen (
    .clk   (clk),
    .arst_n(arst_n)
  );

  softermax_top i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .score_data (score_data),
    .score_last (score_last),
    .score_valid(score_valid),
    .score_ready(score_ready),
    .num_data   (num_data),
    .num_max    (num_max),
    .num_last   (num_last),
    .row_sum    (row_sum),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  function automatic int row_len(input int r);
    return 1 + ((r * 7) % 12);
  endfunction

  function automatic int total_beats();
    int total;
    total = 1 + QP_LEN;
    for (int r = 0; r < RAND_ROWS + BP_ROWS; r++) begin
      total += row_len(r);
    end
    return total;
  endfunction

  // Chord k joins 2^(k/4) and 2^((k+1)/4); slope in Q.8, intercept in Q.12
  task automatic build_chord_tables();
    real lo;
    real hi;
    real m;
    for (int k = 0; k < 4; k++) begin
      lo = $pow(2.0, k / 4.0);
      hi = $pow(2.0, (k + 1) / 4.0);
      m = (hi - lo) * 4.0;
      chord_slope[k] = $rtoi(m * (2.0 ** softermax_pkg::SLOPE_FRAC_WIDTH) + 0.5);
      chord_icpt[k] = $rtoi((lo - m * k / 4.0) * (2.0 ** softermax_pkg::ICPT_FRAC_WIDTH) + 0.5);
    end
  endtask

  // Chord value of 2^d for d <= 0 in Q4.4, floored to Q1.7 and capped at 1.0
  function automatic int pow2_model(input int d);
    int n;
    int f;
    int v;
    int one;
    n = d >>> FRAC;
    f = d - (n << FRAC);
    v = (f * chord_slope[f >> 2] + chord_icpt[f >> 2]) >> (-n);
    v = v >> (softermax_pkg::ICPT_FRAC_WIDTH - softermax_pkg::OUT_FRAC_WIDTH);
    one = 1 << softermax_pkg::OUT_FRAC_WIDTH;
    return (v > one) ? one : v;
  endfunction

  task automatic model_beat(input logic [softermax_pkg::IN_WIDTH-1:0] data, input logic last);
    int s;
    int c;
    int new_max;
    int delta;
    int num;
    int sum;
    s = int'($signed(data));
    c = (s + (1 << FRAC) - 1) >>> FRAC;
    new_max = (!row_open || c > row_max) ? c : row_max;
    delta = row_open ? new_max - row_max : 0;
    num = pow2_model(s - (new_max << FRAC));
    sum = ((run_sum >> delta) + num) & ((1 << softermax_pkg::SUM_WIDTH) - 1);
    exp_q.push_back({num[softermax_pkg::OUT_WIDTH-1:0], new_max[softermax_pkg::INT_WIDTH-1:0],
                     last, sum[softermax_pkg::SUM_WIDTH-1:0]});
    row_open = !last;
    row_max = last ? 0 : new_max;
    run_sum = last ? 0 : sum;
  endtask

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  // Model on accepted inputs, pop on delivered outputs
  always @(posedge clk) begin
    if (arst_n) begin
      if (score_valid && score_ready) begin
        model_beat(score_data, score_last);
        in_cycle = cycle_cnt;
        beats_in++;
      end
      if (out_valid && out_ready) begin
        out_cycle = cycle_cnt;
        beats_out++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
    end
    head_valid <= (exp_q.size() > 0);
    if (exp_q.size() > 0) begin
      {head_data, head_max, head_last, head_sum} <= exp_q[0];
    end
  end

  a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && out_ready) |-> head_valid)
    else begin
      $display("Error in %s: output beat arrived with no beat expected", test_name);
      err_count++;
    end

  a_num_max: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && out_ready && head_valid) |-> (num_max == head_max))
    else begin
      $display("Fail %s num_max expected %0d actual %0d", test_name,
               $signed($sampled(head_max)), $signed($sampled(num_max)));
      err_count++;
    end

  a_num_data: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && out_ready && head_valid) |-> (num_data == head_data))
    else begin
      $display("Fail %s num_data expected %0d actual %0d", test_name,
               $sampled(head_data), $sampled(num_data));
      err_count++;
    end

  a_num_last: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && out_ready && head_valid) |-> (num_last == head_last))
    else begin
      $display("Fail %s num_last expected %0b actual %0b", test_name,
               $sampled(head_last), $sampled(num_last));
      err_count++;
    end

  a_row_sum: assert property (@(posedge clk) disable iff (!arst_n)
      (out_valid && out_ready && head_valid && head_last) |-> (row_sum == head_sum))
    else begin
      $display("Fail %s row_sum expected %0d actual %0d", test_name,
               $sampled(head_sum), $sampled(row_sum));
      err_count++;
    end

  // Random stalls on the output while bp_on is set
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      out_ready = bp_on ? ($urandom_range(9) >= 4) : 1'b1;
    end
  end

  // Entered DRIVE_DELAY after an edge, returns at the same offset
  task automatic send_beat(input logic [softermax_pkg::IN_WIDTH-1:0] data, input logic last);
    score_data = data;
    score_last = last;
    score_valid = 1'b1;
    do begin
      @(posedge clk);
    end while (!score_ready);
    #DRIVE_DELAY;
    score_valid = 1'b0;
  endtask

  task automatic send_row(input int len);
    int s;
    for (int i = 0; i < len; i++) begin
      s = int'($urandom_range(240)) - 128;
      send_beat(s[softermax_pkg::IN_WIDTH-1:0], i == len - 1);
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = err_count;
    tests_run++;
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic finish_test();
    drain();
    if (err_count != test_errs) begin
      tests_failed++;
    end
    $display("Test %s: %0d errors", test_name, err_count - test_errs);
  endtask

  initial begin : watchdog
    int limit;
    limit = total_beats() * 20 + 200;
    repeat (limit) @(posedge clk);
    $display("Error: timeout after %0d cycles in %s, the pipeline stopped delivering beats",
             limit, test_name);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : main
    int s;
    void'($urandom(32'hb401));
    score_data = '0;
    score_last = 1'b0;
    score_valid = 1'b0;
    bp_on = 1'b0;
    row_open = 1'b0;
    row_max = 0;
    run_sum = 0;
    build_chord_tables();
    @(posedge arst_n);
    @(posedge clk);
    #DRIVE_DELAY;

    start_test("reset");
    assert (!out_valid && score_ready) else begin
      $display("Error in reset: out_valid is high or score_ready is low after reset");
      err_count++;
    end
    finish_test();

    start_test("latency");
    send_beat(8'h10, 1'b1);
    drain();
    assert (out_cycle - in_cycle == LATENCY) else begin
      $display("Fail latency cycles expected %0d actual %0d", LATENCY, out_cycle - in_cycle);
      err_count++;
    end
    finish_test();

    start_test("quarter_points");
    for (int i = 0; i < QP_LEN; i++) begin
      s = QP_SCORES[i];
      send_beat(s[softermax_pkg::IN_WIDTH-1:0], i == QP_LEN - 1);
    end
    finish_test();

    start_test("random_rows");
    for (int r = 0; r < RAND_ROWS; r++) begin
      send_row(row_len(r));
    end
    finish_test();

    start_test("back_pressure");
    bp_on = 1'b1;
    for (int r = RAND_ROWS; r < RAND_ROWS + BP_ROWS; r++) begin
      send_row(row_len(r));
    end
    finish_test();
    bp_on = 1'b0;

    assert (beats_in == beats_out) else begin
      $display("Error: %0d beats sent but %0d beats delivered", beats_in, beats_out);
      err_count++;
    end
    $display("Summary: %0d tests, %0d failed, %0d errors, %0d beats", tests_run, tests_failed,
             err_count, beats_out);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: build.f
hdl/softermax_pkg.sv
hdl/skid_buffer.sv
hdl/softermax_running_max.sv
hdl/softermax_lpw_pow2.sv
hdl/softermax_denom_accum.sv
hdl/softermax_top.sv
sim/tb_clock_gen.sv
sim/softermax_tb.sv
